//--- Makefile
TOP := rv32_core_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-Mdir obj_dir -o sim -f compile.f

run: compile
	./obj_dir/sim | tee sim.log
	grep -qx "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

//--- compile.f
source/rv32_pkg.sv
source/alu.sv
source/imm_gen.sv
source/register_file.sv
source/pc_unit.sv
source/sequencer.sv
source/rv32_core.sv
verification/tb_clock_gen.sv
verification/rv32_core_tb.sv

//--- source/alu.sv
`timescale 1ns/100ps

module alu
    import rv32_pkg::*;
(
    input  alu_op_t alu_op,
    input  word_t   in_a,
    input  word_t   in_b,
    output word_t   result,
    output logic    zero,
    output logic    lt,
    output logic    ltu
);

    logic [4:0] shamt; // Only low 5 bits shift

    assign shamt = in_b[4:0];

    always_comb begin
        case (alu_op)
            ADD: result = in_a + in_b;
            SUB: result = in_a - in_b;
            SLL: result = in_a << shamt;
            SRL: result = in_a >> shamt;             // Zero fill
            SRA: result = $signed(in_a) >>> shamt;   // Sign fill
            XOR: result = in_a ^ in_b;
            OR:  result = in_a | in_b;
            AND: result = in_a & in_b;
            default: result = in_a + in_b;
        endcase
    end

    // Compare flags, independent of the selected op
    // Branches, SLT and SLTU all read these
    assign zero = (in_a == in_b);
    assign lt   = ($signed(in_a) < $signed(in_b)); // Signed order
    assign ltu  = (in_a < in_b);                   // Unsigned order

endmodule

//--- source/imm_gen.sv
`timescale 1ns/100ps

module imm_gen
    import rv32_pkg::*;
(
    input  instr_t instr,
    output word_t  imm
);

    opcode_t opcode;

    assign opcode = instr[6:0];

    always_comb begin
        case (opcode)
            // I format, also covers JALR
            // Shift amount sits in bits 24:20 and the ALU takes only the low 5 bits
            OP_IMM, OP_JALR: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            OP_BRANCH: begin // B format, halfword offset
                imm = {{19{instr[31]}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                imm = {instr[31:12], 12'b0}; // U format, upper 20 bits
            end
            OP_JAL: begin // J format
                imm = {{11{instr[31]}}, instr[31], instr[19:12],
                       instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0; // R-type and unknown opcodes carry no immediate
            end
        endcase
    end

endmodule

//--- source/pc_unit.sv
`timescale 1ns/100ps

module pc_unit
    import rv32_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       pc_load,
    input  jump_kind_t jump_kind,
    input  funct3_t    funct3,
    input  word_t      imm,
    input  word_t      alu_result,
    input  logic       alu_zero,
    input  logic       alu_lt,
    input  logic       alu_ltu,
    output word_t      pc
);

    logic  take_branch;
    word_t next_pc;

    // Branch condition from the registered compare flags
    always_comb begin
        case (funct3)
            F3_BEQ:  take_branch = alu_zero;
            F3_BNE:  take_branch = !alu_zero;
            F3_BLT:  take_branch = alu_lt;
            F3_BGE:  take_branch = !alu_lt;
            F3_BLTU: take_branch = alu_ltu;
            F3_BGEU: take_branch = !alu_ltu;
            default: take_branch = 1'b0; // Reserved encodings fall through
        endcase
    end

    always_comb begin
        case (jump_kind)
            JAL:     next_pc = pc + imm;
            JALR:    next_pc = {alu_result[31:1], 1'b0}; // rs1 + imm, LSB dropped
            BRANCH:  next_pc = take_branch ? (pc + imm) : (pc + PC_STEP);
            default: next_pc = pc + PC_STEP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (pc_load) begin
            pc <= next_pc; // Once per instruction, end of WRITEBACK
        end
    end

    // Every update lands on a word boundary
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc_load |=> (pc[1:0] == 2'b00));

endmodule

//--- source/register_file.sv
`timescale 1ns/100ps

module register_file
    import rv32_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t regs [1:31]; // x1..x31, x0 not stored

    // Write at the edge that ends the write cycle
    always_ff @(posedge clk) begin
        if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Combinational reads
    // x0 is hardwired zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- source/rv32_core.sv
`timescale 1ns/100ps

module rv32_core
    import rv32_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    output word_t     imem_addr,
    input  instr_t    imem_data,
    output logic      reg_wr_en,
    output reg_addr_t reg_wr_addr,
    output word_t     reg_wr_data
);

    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    word_t      rs1_data;
    word_t      rs2_data;
    logic       pc_load;
    jump_kind_t jump_kind;
    funct3_t    funct3;
    word_t      imm;
    word_t      alu_result;
    logic       alu_zero;
    logic       alu_lt;
    logic       alu_ltu;

    // imem_addr is the PC itself
    sequencer u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .imem_data  (imem_data),
        .pc         (imem_addr),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .wr_en      (reg_wr_en),   // Also visible at the core boundary
        .wr_addr    (reg_wr_addr),
        .wr_data    (reg_wr_data),
        .pc_load    (pc_load),
        .jump_kind  (jump_kind),
        .funct3     (funct3),
        .imm        (imm),
        .alu_result (alu_result),
        .alu_zero   (alu_zero),
        .alu_lt     (alu_lt),
        .alu_ltu    (alu_ltu)
    );

    register_file u_register_file (
        .clk      (clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (reg_wr_en),
        .wr_addr  (reg_wr_addr),
        .wr_data  (reg_wr_data)
    );

    pc_unit u_pc_unit (
        .clk        (clk),
        .reset      (reset),
        .pc_load    (pc_load),
        .jump_kind  (jump_kind),
        .funct3     (funct3),
        .imm        (imm),
        .alu_result (alu_result),
        .alu_zero   (alu_zero),
        .alu_lt     (alu_lt),
        .alu_ltu    (alu_ltu),
        .pc         (imem_addr)
    );

endmodule

//--- source/rv32_pkg.sv
package rv32_pkg;

    // Widths with a meaning
    typedef logic [31:0] word_t;      // Data word, address or PC
    typedef logic [31:0] instr_t;     // Raw instruction
    typedef logic [4:0]  reg_addr_t;  // Register index
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // Major opcodes of the supported groups
    localparam opcode_t OP_REG    = 7'b0110011; // R-type arithmetic
    localparam opcode_t OP_IMM    = 7'b0010011; // I-type arithmetic
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;

    // Branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // Arithmetic funct3, shared by R and I type
    localparam funct3_t F3_ADD  = 3'b000; // ADD or SUB by bit 30
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101; // SRL or SRA by bit 30
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // ALU operations
    typedef enum logic [2:0] {
        ADD,
        SUB,
        SLL,
        SRL,
        SRA,
        XOR,
        OR,
        AND
    } alu_op_t;

    // How the PC unit forms the next PC
    typedef enum logic [1:0] {
        NONE,   // Fall through
        BRANCH, // Conditional, pc + imm when taken
        JAL,    // pc + imm
        JALR    // ALU result, bit 0 cleared
    } jump_kind_t;

    // Instruction sequencer states
    typedef enum logic [1:0] {
        FETCH,
        DECODE,
        EXECUTE,
        WRITEBACK
    } state_t;

    localparam word_t RESET_PC = 32'h0000_0000; // First instruction
    localparam word_t PC_STEP  = 32'd4;         // One instruction word

endpackage

//--- source/sequencer.sv
`timescale 1ns/100ps

module sequencer
    import rv32_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  instr_t     imem_data,
    input  word_t      pc,
    output reg_addr_t  rs1_addr,
    output reg_addr_t  rs2_addr,
    input  word_t      rs1_data,
    input  word_t      rs2_data,
    output logic       wr_en,
    output reg_addr_t  wr_addr,
    output word_t      wr_data,
    output logic       pc_load,
    output jump_kind_t jump_kind,
    output funct3_t    funct3,
    output word_t      imm,
    output word_t      alu_result,
    output logic       alu_zero,
    output logic       alu_lt,
    output logic       alu_ltu
);

    state_t  state;
    instr_t  instr_reg;  // Held from FETCH to the end of WRITEBACK
    opcode_t opcode;
    word_t   imm_value;  // Straight from imm_gen
    word_t   a_next;     // Operand A before DECODE registers it
    word_t   b_next;
    word_t   op_a;
    word_t   op_b;
    alu_op_t alu_op;
    alu_op_t arith_op;   // Op for R and I type groups
    word_t   alu_out;
    logic    alu_out_zero;
    logic    alu_out_lt;
    logic    alu_out_ltu;
    logic    writes_rd;

    // Instruction fields
    assign opcode   = instr_reg[6:0];
    assign funct3   = instr_reg[14:12];
    assign wr_addr  = instr_reg[11:7];
    assign rs1_addr = instr_reg[19:15];
    assign rs2_addr = instr_reg[24:20];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            case (state)
                FETCH:     state <= DECODE;
                DECODE:    state <= EXECUTE;
                EXECUTE:   state <= WRITEBACK;
                WRITEBACK: state <= FETCH;
                default:   state <= FETCH;
            endcase
        end
    end

    // Datapath registers loaded by state
    always_ff @(posedge clk) begin
        case (state)
            FETCH: instr_reg <= imem_data; // Word at imem_addr this cycle
            DECODE: begin
                op_a <= a_next;
                op_b <= b_next;
                imm  <= imm_value;
            end
            EXECUTE: begin
                alu_result <= alu_out;
                alu_zero   <= alu_out_zero;
                alu_lt     <= alu_out_lt;
                alu_ltu    <= alu_out_ltu;
            end
            default: ;
        endcase
    end

    // Bit 30 picks SUB only for R-type since ADDI uses it as an immediate bit
    always_comb begin
        case (funct3)
            F3_ADD:  arith_op = (opcode == OP_REG && instr_reg[30]) ? SUB : ADD;
            F3_SLL:  arith_op = SLL;
            F3_SLT:  arith_op = SUB;  // Result comes from lt flag
            F3_SLTU: arith_op = SUB;  // Result comes from ltu flag
            F3_XOR:  arith_op = XOR;
            F3_SR:   arith_op = instr_reg[30] ? SRA : SRL;
            F3_OR:   arith_op = OR;
            F3_AND:  arith_op = AND;
            default: arith_op = ADD;
        endcase
    end

    // Operand sources, ALU op and rd usage per opcode
    always_comb begin
        alu_op    = ADD;
        a_next    = rs1_data;
        b_next    = imm_value;
        writes_rd = 1'b0;
        jump_kind = NONE;
        case (opcode)
            OP_REG: begin
                b_next    = rs2_data;
                alu_op    = arith_op;
                writes_rd = 1'b1;
            end
            OP_IMM: begin
                alu_op    = arith_op;
                writes_rd = 1'b1;
            end
            OP_LUI:   writes_rd = 1'b1; // ALU idle and imm written directly
            OP_AUIPC: begin
                a_next    = pc;
                writes_rd = 1'b1;
            end
            OP_JAL: begin
                a_next    = pc;
                b_next    = PC_STEP;
                writes_rd = 1'b1;
                jump_kind = JAL;
            end
            OP_JALR: begin // rs1 + imm gives the target
                writes_rd = 1'b1;
                jump_kind = JALR;
            end
            OP_BRANCH: begin
                b_next    = rs2_data; // Flags compare rs1 with rs2
                alu_op    = SUB;
                jump_kind = BRANCH;
            end
            default: ; // Unknown opcode retires as a no-op
        endcase
    end

    always_comb begin
        case (opcode)
            OP_LUI:  wr_data = imm;
            OP_JALR: wr_data = pc + PC_STEP; // Link address, ALU holds the target
            OP_REG, OP_IMM: begin
                if (funct3 == F3_SLT) begin
                    wr_data = word_t'(alu_lt);
                end else if (funct3 == F3_SLTU) begin
                    wr_data = word_t'(alu_ltu);
                end else begin
                    wr_data = alu_result;
                end
            end
            default: wr_data = alu_result; // AUIPC sum or JAL link
        endcase
    end

    // One-cycle strobes in WRITEBACK
    assign pc_load = (state == WRITEBACK);
    assign wr_en   = pc_load && writes_rd && (wr_addr != '0);

    alu u_alu (
        .alu_op (alu_op),
        .in_a   (op_a),
        .in_b   (op_b),
        .result (alu_out),
        .zero   (alu_out_zero),
        .lt     (alu_out_lt),
        .ltu    (alu_out_ltu)
    );

    imm_gen u_imm_gen (
        .instr (instr_reg),
        .imm   (imm_value)
    );

    // JAL link from the ALU path matches the PC of the instruction plus one word
    a_jal_link: assert property (@(posedge clk) disable iff (reset)
        wr_en && (opcode == OP_JAL) |-> (wr_data == pc + PC_STEP));

    // Next PC update follows four cycles later
    a_pc_load_period: assert property (@(posedge clk) disable iff (reset)
        pc_load |=> !pc_load ##1 !pc_load ##1 !pc_load ##1 pc_load);

endmodule

//--- verification/rv32_core_tb.sv
`timescale 1ns/100ps

module rv32_core_tb
    import rv32_pkg::*;
();

    localparam instr_t SELF_JUMP = {25'b0, OP_JAL}; // JAL x0, 0

    logic      clk;
    logic      reset;
    word_t     imem_addr;
    instr_t    imem_data;
    logic      reg_wr_en;
    reg_addr_t reg_wr_addr;
    word_t     reg_wr_data;

    instr_t prog [0:255];        // Program ROM with one word per entry
    int     prog_test [0:255];   // Test that owns each word
    word_t  prog_len = '0;
    logic   program_built = 1'b0;
    int     build_test = 0;

    word_t  ref_regs [0:31];     // Reference register model
    word_t  ref_pc;
    word_t  lfsr_state = 32'h6076_6018;

    int     active_test = 0;
    int     test_errs [0:5] = '{0, 0, 0, 0, 0, 0};
    int     errors = 0;
    int     tests_done = 0;
    int     tests_failed = 0;

    tb_clock_gen u_tb_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    rv32_core u_rv32_core (
        .clk         (clk),
        .reset       (reset),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .reg_wr_en   (reg_wr_en),
        .reg_wr_addr (reg_wr_addr),
        .reg_wr_data (reg_wr_data)
    );

    // Word at imem_addr or a self jump past the end
    assign imem_data = ((imem_addr >> 2) < prog_len) ? prog[imem_addr[9:2]] : SELF_JUMP;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic word_t lfsr_next(word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t draw_bits(int count);
        word_t bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state); // One step per bit
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // RV32I encodings
    function automatic instr_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                      funct3_t f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic instr_t i_type(logic [11:0] imm, reg_addr_t rs1, funct3_t f3,
                                      reg_addr_t rd, opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instr_t u_type(logic [19:0] imm, reg_addr_t rd, opcode_t op);
        return {imm, rd, op};
    endfunction

    function automatic instr_t b_type(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                      funct3_t f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic instr_t j_type(logic [20:0] off, reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    task automatic emit(instr_t ins);
        prog[prog_len[7:0]] = ins;
        prog_test[prog_len[7:0]] = build_test;
        prog_len = prog_len + 32'd1;
    endtask

    // LUI then ADDI with the upper part rounded for the signed low 12 bits
    task automatic load_const(reg_addr_t rd, word_t value);
        word_t hi;
        hi = value + 32'h800;
        emit(u_type(hi[31:12], rd, OP_LUI));
        emit(i_type(value[11:0], rd, F3_ADD, rd, OP_IMM));
    endtask

    // Branch over one marker increment of x29
    task automatic branch_step(funct3_t f3, reg_addr_t rs1, reg_addr_t rs2);
        emit(b_type(13'd8, rs2, rs1, f3));
        emit(i_type(12'd1, 5'd29, F3_ADD, 5'd29, OP_IMM));
    endtask

    task automatic build_program();
        word_t   t;
        word_t   target;
        funct3_t imm_ops [0:5];
        imm_ops = '{F3_ADD, F3_SLT, F3_SLTU, F3_XOR, F3_OR, F3_AND};
        build_test = 1; // R-type
        load_const(5'd1, draw_bits(32) | 32'h8000_0000); // Negative so SRA differs from SRL
        load_const(5'd2, draw_bits(32) | 32'h1);         // Nonzero shift amount
        emit(r_type(7'h00, 5'd2, 5'd1, F3_ADD, 5'd3));
        emit(r_type(7'h20, 5'd2, 5'd1, F3_ADD, 5'd4));   // SUB
        emit(r_type(7'h00, 5'd2, 5'd1, F3_SLL, 5'd5));
        emit(r_type(7'h00, 5'd2, 5'd1, F3_SLT, 5'd6));
        emit(r_type(7'h00, 5'd2, 5'd1, F3_SLTU, 5'd7));
        emit(r_type(7'h00, 5'd2, 5'd1, F3_XOR, 5'd8));
        emit(r_type(7'h00, 5'd2, 5'd1, F3_SR, 5'd9));    // SRL
        emit(r_type(7'h20, 5'd2, 5'd1, F3_SR, 5'd10));   // SRA
        emit(r_type(7'h00, 5'd2, 5'd1, F3_OR, 5'd11));
        emit(r_type(7'h00, 5'd2, 5'd1, F3_AND, 5'd12));
        emit(r_type(7'h00, 5'd1, 5'd2, F3_SLT, 5'd13));  // Swapped order
        emit(r_type(7'h00, 5'd1, 5'd2, F3_SLTU, 5'd14));
        build_test = 2; // I-type, LUI, AUIPC
        for (int k = 0; k < 6; k++) begin
            t = draw_bits(12);
            emit(i_type(t[11:0], 5'd1, imm_ops[k], reg_addr_t'(15 + k), OP_IMM));
        end
        t = draw_bits(5) | 32'h1; // Nonzero shift amounts
        emit(i_type({7'h00, t[4:0]}, 5'd1, F3_SLL, 5'd21, OP_IMM));
        t = draw_bits(5) | 32'h1;
        emit(i_type({7'h00, t[4:0]}, 5'd1, F3_SR, 5'd22, OP_IMM)); // SRLI
        t = draw_bits(5) | 32'h1;
        emit(i_type({7'h20, t[4:0]}, 5'd1, F3_SR, 5'd23, OP_IMM)); // SRAI
        t = draw_bits(20);
        emit(u_type(t[19:0], 5'd24, OP_LUI));
        t = draw_bits(20);
        emit(u_type(t[19:0], 5'd25, OP_AUIPC));
        build_test = 3; // Branches with x1 negative, x27 positive and x28 equal to x27
        emit(i_type(12'd0, 5'd0, F3_ADD, 5'd29, OP_IMM)); // Marker counter cleared
        load_const(5'd27, draw_bits(32) & 32'h7fff_ffff);
        emit(i_type(12'd0, 5'd27, F3_ADD, 5'd28, OP_IMM));
        branch_step(F3_BEQ, 5'd27, 5'd28);  // Taken
        branch_step(F3_BEQ, 5'd27, 5'd1);
        branch_step(F3_BNE, 5'd27, 5'd1);   // Taken
        branch_step(F3_BNE, 5'd27, 5'd28);
        branch_step(F3_BLT, 5'd1, 5'd27);   // Taken on signed order
        branch_step(F3_BLT, 5'd27, 5'd1);
        branch_step(F3_BGE, 5'd27, 5'd1);   // Taken
        branch_step(F3_BGE, 5'd1, 5'd27);
        branch_step(F3_BLTU, 5'd27, 5'd1);  // Taken on unsigned order
        branch_step(F3_BLTU, 5'd1, 5'd27);
        branch_step(F3_BGEU, 5'd1, 5'd27);  // Taken
        branch_step(F3_BGEU, 5'd27, 5'd1);
        build_test = 4; // Jumps
        emit(j_type(21'd8, 5'd30));
        emit(i_type(12'd1, 5'd29, F3_ADD, 5'd29, OP_IMM)); // Skipped
        target = (prog_len + 32'd4) << 2;                   // Past JALR and its marker
        load_const(5'd31, target - 32'd4);                  // Base + 5 is odd
        emit(i_type(12'd5, 5'd31, 3'b000, 5'd28, OP_JALR));
        emit(i_type(12'd1, 5'd29, F3_ADD, 5'd29, OP_IMM)); // Skipped
        build_test = 5; // x0 destination and source
        emit(r_type(7'h00, 5'd2, 5'd1, F3_ADD, 5'd0));
        emit(i_type(12'd5, 5'd1, F3_ADD, 5'd0, OP_IMM));
        emit(u_type(20'hABCDE, 5'd0, OP_LUI));
        emit(j_type(21'd4, 5'd0));
        emit(r_type(7'h00, 5'd2, 5'd0, F3_ADD, 5'd3));    // x3 = x2
        emit(r_type(7'h00, 5'd0, 5'd1, F3_ADD, 5'd4));    // x4 = x1
        program_built = 1'b1;
    endtask

    function automatic word_t arith(funct3_t f3, logic alt, word_t a, word_t b);
        case (f3)
            F3_ADD:  return alt ? a - b : a + b;
            F3_SLL:  return a << b[4:0];
            F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
            F3_XOR:  return a ^ b;
            F3_SR: begin
                if (alt) return $signed(a) >>> b[4:0]; // Sign fill
                return a >> b[4:0];
            end
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(funct3_t f3, word_t a, word_t b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            F3_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // One instruction on the reference model
    task automatic model_step(input instr_t ins, output logic exp_wr,
                              output reg_addr_t exp_rd, output word_t exp_data);
        word_t a;
        word_t b;
        word_t imm_i;
        word_t imm_b;
        word_t imm_u;
        word_t imm_j;
        word_t next_pc;
        a       = ref_regs[ins[19:15]];
        b       = ref_regs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u   = {ins[31:12], 12'b0};
        imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        exp_rd  = ins[11:7];
        exp_wr  = 1'b1;
        exp_data = '0;
        next_pc = ref_pc + 32'd4;
        case (ins[6:0])
            OP_REG:   exp_data = arith(ins[14:12], ins[30], a, b);
            OP_IMM:   exp_data = arith(ins[14:12], ins[30] && (ins[14:12] == F3_SR), a, imm_i);
            OP_LUI:   exp_data = imm_u;
            OP_AUIPC: exp_data = ref_pc + imm_u;
            OP_JAL: begin
                exp_data = ref_pc + 32'd4;
                next_pc  = ref_pc + imm_j;
            end
            OP_JALR: begin
                exp_data   = ref_pc + 32'd4;
                next_pc    = a + imm_i;
                next_pc[0] = 1'b0;
            end
            OP_BRANCH: begin
                exp_wr = 1'b0;
                if (branch_taken(ins[14:12], a, b)) next_pc = ref_pc + imm_b;
            end
            default: exp_wr = 1'b0;
        endcase
        if (exp_rd == 5'd0) exp_wr = 1'b0; // x0 never written
        if (exp_wr) ref_regs[exp_rd] = exp_data;
        ref_pc = next_pc;
    endtask

    task automatic report_mismatch(string name, word_t exp, word_t act);
        $display("FAIL %s: expected %08h, got %08h (pc %08h)", name, exp, act, imem_addr);
        errors++;
        test_errs[active_test]++;
    endtask

    function automatic string test_name(int id);
        case (id)
            0:       return "reset";
            1:       return "r-type";
            2:       return "i-type and upper immediates";
            3:       return "branches";
            4:       return "jal and jalr";
            default: return "x0 handling";
        endcase
    endfunction

    task automatic finish_test(int id);
        tests_done++;
        if (test_errs[id] == 0) begin
            $display("test %0d %s: passed", id + 1, test_name(id));
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", id + 1, test_name(id), test_errs[id]);
        end
    endtask

    // Lockstep run against the model at falling edges
    initial begin
        instr_t    ins;
        word_t     cur_pc;
        logic      exp_wr;
        reg_addr_t exp_rd;
        word_t     exp_data;
        build_program();
        for (int r = 0; r < 32; r++) ref_regs[r] = '0;
        ref_pc = RESET_PC;
        @(negedge clk);
        while (reset) begin
            assert (imem_addr == RESET_PC) else report_mismatch("imem_addr", RESET_PC, imem_addr);
            assert (!reg_wr_en) else report_mismatch("reg_wr_en", '0, word_t'(reg_wr_en));
            @(negedge clk);
        end
        finish_test(0);
        active_test = prog_test[0];
        while (ref_pc < (prog_len << 2)) begin
            if (prog_test[ref_pc[9:2]] != active_test) begin
                finish_test(active_test);
                active_test = prog_test[ref_pc[9:2]];
            end
            cur_pc = ref_pc;
            ins    = prog[ref_pc[9:2]];
            model_step(ins, exp_wr, exp_rd, exp_data);
            for (int cyc = 0; cyc < 4; cyc++) begin
                assert (imem_addr == cur_pc) else report_mismatch("imem_addr", cur_pc, imem_addr);
                if (cyc == 3) begin // WRITEBACK
                    assert (reg_wr_en == exp_wr)
                        else report_mismatch("reg_wr_en", word_t'(exp_wr), word_t'(reg_wr_en));
                    if (exp_wr) begin
                        assert (reg_wr_addr == exp_rd)
                            else report_mismatch("reg_wr_addr", word_t'(exp_rd),
                                                 word_t'(reg_wr_addr));
                        assert (reg_wr_data == exp_data)
                            else report_mismatch("reg_wr_data", exp_data, reg_wr_data);
                    end
                end else begin
                    assert (!reg_wr_en) else report_mismatch("reg_wr_en", '0, word_t'(reg_wr_en));
                end
                @(negedge clk);
            end
        end
        assert (imem_addr == ref_pc) else report_mismatch("imem_addr", ref_pc, imem_addr);
        finish_test(active_test);
        $display("Summary: %0d tests, %0d failed, %0d errors", tests_done, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Four 20 ns cycles per instruction plus reset and slack
    initial begin
        wait (program_built);
        #((prog_len * 32'd4 + 32'd16) * 32'd20);
        $display("Watchdog expired, the program did not finish");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period, first rise at 10 ns
    end

    // Held over four rising edges, dropped just after the last one
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule
